// ==== hw/data_cache_params.svh ====
`ifndef DATA_CACHE_PARAMS_SVH
`define DATA_CACHE_PARAMS_SVH

// address and data word width
`define WORD_W 16

// a line is four words
`define LINE_WORDS 4
`define LINE_W 64

// address split into tag, index and offset
`define OFFSET_W 2
`define INDEX_W 1
`define SETS 2
`define TAG_W 13

`endif

// ==== hw/cache_pkg.sv ====
`default_nettype none

`include "data_cache_params.svh"

package cache_pkg;

    // one cache line, seen either as a flat vector or as four words
    // word 0 sits in the low bits
    typedef union packed {
        logic [`LINE_W-1:0] flat;
        logic [`LINE_WORDS-1:0][`WORD_W-1:0] words;
    } line_u;

endpackage

`default_nettype wire

// ==== hw/cache_way.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "data_cache_params.svh"

module cache_way (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [`INDEX_W-1:0]   index,
    input  logic [`TAG_W-1:0]     req_tag,
    input  logic [`OFFSET_W-1:0]  offset,
    input  logic                  line_we,
    input  logic                  fill_we,
    input  logic                  fill_dirty,
    input  logic                  set_dirty,
    input  logic                  recent_we,
    input  logic                  recent_value,
    input  cache_pkg::line_u      line_in,
    output logic                  hit,
    output logic                  valid,
    output logic                  dirty,
    output logic                  recent,
    output logic [`TAG_W-1:0]     victim_tag,
    output cache_pkg::line_u      line,
    output logic [`WORD_W-1:0]    word
);

    // per set storage
    logic [`TAG_W-1:0] tag_mem [`SETS];
    cache_pkg::line_u  line_mem [`SETS];
    logic [`SETS-1:0]  valid_bits;
    logic [`SETS-1:0]  dirty_bits;
    logic [`SETS-1:0]  recent_bits;

    // state bits of every set
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            valid_bits  <= '0;
            dirty_bits  <= '0;
            recent_bits <= '0;
        end else begin
            if (fill_we) begin
                valid_bits[index] <= 1'b1;
                dirty_bits[index] <= fill_dirty;
            end else if (set_dirty) begin
                dirty_bits[index] <= 1'b1;
            end
            if (recent_we) begin
                recent_bits[index] <= recent_value;
            end
        end
    end

    // a fill brings in the tag of the request
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[index] <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (line_we) begin
            line_mem[index] <= line_in;
        end
    end

    // asynchronous read of the addressed set
    assign valid      = valid_bits[index];
    assign dirty      = dirty_bits[index];
    assign recent     = recent_bits[index];
    assign victim_tag = tag_mem[index];
    assign hit        = valid && (tag_mem[index] == req_tag);
    assign line       = line_mem[index];

    // word at the request offset
    assign word = line.words[offset];

    // a fill sets its own dirty value, a separate dirty set in the same cycle is a conflict
    fill_vs_set_dirty: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(fill_we && set_dirty)
    );

endmodule

`default_nettype wire

// ==== hw/cache_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "data_cache_params.svh"

module cache_controller (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  cpu_valid,
    input  logic                  cpu_read,
    input  logic                  cpu_write,
    input  logic [`WORD_W-1:0]    cpu_addr,
    input  logic [`WORD_W-1:0]    cpu_wdata,
    output logic [`WORD_W-1:0]    cpu_rdata,
    output logic                  cpu_read_ready,
    output logic                  cpu_write_ack,
    input  logic                  way0_hit,
    input  logic                  way0_dirty,
    input  logic                  way0_valid,
    input  logic                  way0_recent,
    input  logic [`TAG_W-1:0]     way0_victim_tag,
    input  cache_pkg::line_u      way0_line,
    input  logic [`WORD_W-1:0]    way0_word,
    output logic                  way0_line_we,
    output logic                  way0_fill_we,
    output logic                  way0_fill_dirty,
    output logic                  way0_set_dirty,
    output logic                  way0_recent_we,
    output logic                  way0_recent_value,
    output cache_pkg::line_u      way0_line_in,
    input  logic                  way1_hit,
    input  logic                  way1_dirty,
    input  logic                  way1_valid,
    input  logic                  way1_recent,
    input  logic [`TAG_W-1:0]     way1_victim_tag,
    input  cache_pkg::line_u      way1_line,
    input  logic [`WORD_W-1:0]    way1_word,
    output logic                  way1_line_we,
    output logic                  way1_fill_we,
    output logic                  way1_fill_dirty,
    output logic                  way1_set_dirty,
    output logic                  way1_recent_we,
    output logic                  way1_recent_value,
    output cache_pkg::line_u      way1_line_in,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic [`WORD_W-1:0]    mem_addr,
    output cache_pkg::line_u      mem_wdata,
    input  cache_pkg::line_u      mem_rdata,
    input  logic                  mem_ready,
    input  logic                  mem_ack
);

    localparam logic [1:0] CHECK      = 2'd0;
    localparam logic [1:0] WRITE_BACK = 2'd1;
    localparam logic [1:0] ALLOCATE   = 2'd2;

    logic [1:0]             state;
    logic [1:0]             next_state;
    // high when way 1 is the line being replaced
    logic                   victim_sel;
    logic                   any_hit;
    logic                   miss_dirty;
    logic [`OFFSET_W-1:0]   offset;
    logic [`INDEX_W-1:0]    index;
    logic [`TAG_W-1:0]      victim_tag;
    cache_pkg::line_u       hit_line;
    cache_pkg::line_u       base_line;
    cache_pkg::line_u       write_line;

    // replace one word of a line
    function automatic cache_pkg::line_u merge_word(
        input cache_pkg::line_u       base,
        input logic [`OFFSET_W-1:0]   sel,
        input logic [`WORD_W-1:0]     data
    );
        cache_pkg::line_u merged;
        merged = base;
        merged.words[sel] = data;
        return merged;
    endfunction

    assign offset  = cpu_addr[`OFFSET_W-1:0];
    assign index   = cpu_addr[`OFFSET_W +: `INDEX_W];
    assign any_hit = way0_hit || way1_hit;

    // victim at a miss is way 0 unless way 0 was used last
    assign miss_dirty = way0_recent ? (way1_valid && way1_dirty)
                                    : (way0_valid && way0_dirty);

    assign cpu_rdata = way0_hit ? way0_word : way1_word;
    assign hit_line  = way0_hit ? way0_line : way1_line;

    // a hit merges into the stored line and a fill into the memory line
    assign base_line    = (state == ALLOCATE) ? mem_rdata : hit_line;
    assign write_line   = cpu_write ? merge_word(base_line, offset, cpu_wdata) : base_line;
    assign way0_line_in = write_line;
    assign way1_line_in = write_line;

    assign way0_fill_dirty = cpu_write;
    assign way1_fill_dirty = cpu_write;

    // memory side follows the state
    assign mem_read   = (state == ALLOCATE);
    assign mem_write  = (state == WRITE_BACK);
    assign victim_tag = victim_sel ? way1_victim_tag : way0_victim_tag;
    assign mem_wdata  = victim_sel ? way1_line : way0_line;
    assign mem_addr   = (state == WRITE_BACK) ? {victim_tag, index, {`OFFSET_W{1'b0}}}
                                              : {cpu_addr[`WORD_W-1:`OFFSET_W],
                                                 {`OFFSET_W{1'b0}}};

    always_comb begin
        next_state        = state;
        cpu_read_ready    = 1'b0;
        cpu_write_ack     = 1'b0;
        way0_line_we      = 1'b0;
        way0_fill_we      = 1'b0;
        way0_set_dirty    = 1'b0;
        way0_recent_we    = 1'b0;
        way0_recent_value = 1'b0;
        way1_line_we      = 1'b0;
        way1_fill_we      = 1'b0;
        way1_set_dirty    = 1'b0;
        way1_recent_we    = 1'b0;
        way1_recent_value = 1'b0;

        case (state)
            CHECK: begin
                if (cpu_valid && (cpu_read || cpu_write)) begin
                    if (any_hit) begin
                        // the hit way becomes the recent one
                        way0_recent_we    = 1'b1;
                        way1_recent_we    = 1'b1;
                        way0_recent_value = way0_hit;
                        way1_recent_value = way1_hit;
                        if (cpu_read) begin
                            cpu_read_ready = 1'b1;
                        end else begin
                            cpu_write_ack  = 1'b1;
                            way0_line_we   = way0_hit;
                            way0_set_dirty = way0_hit;
                            way1_line_we   = way1_hit;
                            way1_set_dirty = way1_hit;
                        end
                    end else if (miss_dirty) begin
                        next_state = WRITE_BACK;
                    end else begin
                        next_state = ALLOCATE;
                    end
                end
            end

            WRITE_BACK: begin
                if (mem_ack) begin
                    next_state = ALLOCATE;
                end
            end

            ALLOCATE: begin
                if (mem_ready) begin
                    // fill the victim and re-check the request from CHECK
                    way0_line_we      = !victim_sel;
                    way0_fill_we      = !victim_sel;
                    way1_line_we      = victim_sel;
                    way1_fill_we      = victim_sel;
                    way0_recent_we    = 1'b1;
                    way1_recent_we    = 1'b1;
                    way0_recent_value = !victim_sel;
                    way1_recent_value = victim_sel;
                    next_state        = CHECK;
                end
            end

            default: begin
                next_state = CHECK;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state      <= CHECK;
            victim_sel <= 1'b0;
        end else begin
            state <= next_state;
            if (state == CHECK && cpu_valid && !any_hit) begin
                victim_sel <= way0_recent;
            end
        end
    end

    // a tag lives in at most one way of a set
    single_way_hit: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(way0_hit && way1_hit)
    );

    one_mem_request: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(mem_read && mem_write)
    );

endmodule

`default_nettype wire

// ==== hw/data_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "data_cache_params.svh"

module data_cache (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  cpu_valid,
    input  logic                  cpu_read,
    input  logic                  cpu_write,
    input  logic [`WORD_W-1:0]    cpu_addr,
    input  logic [`WORD_W-1:0]    cpu_wdata,
    output logic [`WORD_W-1:0]    cpu_rdata,
    output logic                  cpu_read_ready,
    output logic                  cpu_write_ack,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic [`WORD_W-1:0]    mem_addr,
    output cache_pkg::line_u      mem_wdata,
    input  cache_pkg::line_u      mem_rdata,
    input  logic                  mem_ready,
    input  logic                  mem_ack
);

    // request address fields
    logic [`TAG_W-1:0]    req_tag;
    logic [`INDEX_W-1:0]  req_index;
    logic [`OFFSET_W-1:0] req_offset;

    assign req_offset = cpu_addr[`OFFSET_W-1:0];
    assign req_index  = cpu_addr[`OFFSET_W +: `INDEX_W];
    assign req_tag    = cpu_addr[`WORD_W-1:`OFFSET_W+`INDEX_W];

    // way 0 lookup and controls
    logic                 way0_hit;
    logic                 way0_valid;
    logic                 way0_dirty;
    logic                 way0_recent;
    logic [`TAG_W-1:0]    way0_victim_tag;
    cache_pkg::line_u     way0_line;
    logic [`WORD_W-1:0]   way0_word;
    logic                 way0_line_we;
    logic                 way0_fill_we;
    logic                 way0_fill_dirty;
    logic                 way0_set_dirty;
    logic                 way0_recent_we;
    logic                 way0_recent_value;
    cache_pkg::line_u     way0_line_in;

    // way 1 lookup and controls
    logic                 way1_hit;
    logic                 way1_valid;
    logic                 way1_dirty;
    logic                 way1_recent;
    logic [`TAG_W-1:0]    way1_victim_tag;
    cache_pkg::line_u     way1_line;
    logic [`WORD_W-1:0]   way1_word;
    logic                 way1_line_we;
    logic                 way1_fill_we;
    logic                 way1_fill_dirty;
    logic                 way1_set_dirty;
    logic                 way1_recent_we;
    logic                 way1_recent_value;
    cache_pkg::line_u     way1_line_in;

    cache_way way0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .index        (req_index),
        .req_tag      (req_tag),
        .offset       (req_offset),
        .line_we      (way0_line_we),
        .fill_we      (way0_fill_we),
        .fill_dirty   (way0_fill_dirty),
        .set_dirty    (way0_set_dirty),
        .recent_we    (way0_recent_we),
        .recent_value (way0_recent_value),
        .line_in      (way0_line_in),
        .hit          (way0_hit),
        .valid        (way0_valid),
        .dirty        (way0_dirty),
        .recent       (way0_recent),
        .victim_tag   (way0_victim_tag),
        .line         (way0_line),
        .word         (way0_word)
    );

    cache_way way1 (
        .clk          (clk),
        .reset_n      (reset_n),
        .index        (req_index),
        .req_tag      (req_tag),
        .offset       (req_offset),
        .line_we      (way1_line_we),
        .fill_we      (way1_fill_we),
        .fill_dirty   (way1_fill_dirty),
        .set_dirty    (way1_set_dirty),
        .recent_we    (way1_recent_we),
        .recent_value (way1_recent_value),
        .line_in      (way1_line_in),
        .hit          (way1_hit),
        .valid        (way1_valid),
        .dirty        (way1_dirty),
        .recent       (way1_recent),
        .victim_tag   (way1_victim_tag),
        .line         (way1_line),
        .word         (way1_word)
    );

    cache_controller controller (
        .clk               (clk),
        .reset_n           (reset_n),
        .cpu_valid         (cpu_valid),
        .cpu_read          (cpu_read),
        .cpu_write         (cpu_write),
        .cpu_addr          (cpu_addr),
        .cpu_wdata         (cpu_wdata),
        .cpu_rdata         (cpu_rdata),
        .cpu_read_ready    (cpu_read_ready),
        .cpu_write_ack     (cpu_write_ack),
        .way0_hit          (way0_hit),
        .way0_dirty        (way0_dirty),
        .way0_valid        (way0_valid),
        .way0_recent       (way0_recent),
        .way0_victim_tag   (way0_victim_tag),
        .way0_line         (way0_line),
        .way0_word         (way0_word),
        .way0_line_we      (way0_line_we),
        .way0_fill_we      (way0_fill_we),
        .way0_fill_dirty   (way0_fill_dirty),
        .way0_set_dirty    (way0_set_dirty),
        .way0_recent_we    (way0_recent_we),
        .way0_recent_value (way0_recent_value),
        .way0_line_in      (way0_line_in),
        .way1_hit          (way1_hit),
        .way1_dirty        (way1_dirty),
        .way1_valid        (way1_valid),
        .way1_recent       (way1_recent),
        .way1_victim_tag   (way1_victim_tag),
        .way1_line         (way1_line),
        .way1_word         (way1_word),
        .way1_line_we      (way1_line_we),
        .way1_fill_we      (way1_fill_we),
        .way1_fill_dirty   (way1_fill_dirty),
        .way1_set_dirty    (way1_set_dirty),
        .way1_recent_we    (way1_recent_we),
        .way1_recent_value (way1_recent_value),
        .way1_line_in      (way1_line_in),
        .mem_read          (mem_read),
        .mem_write         (mem_write),
        .mem_addr          (mem_addr),
        .mem_wdata         (mem_wdata),
        .mem_rdata         (mem_rdata),
        .mem_ready         (mem_ready),
        .mem_ack           (mem_ack)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held low over three rising edges, released on a falling edge
    initial begin
        reset_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/tb_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "data_cache_params.svh"

module tb_memory (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                mem_read,
    input  logic                mem_write,
    input  logic [`WORD_W-1:0]  mem_addr,
    input  logic [`LINE_W-1:0]  mem_wdata,
    output logic [`LINE_W-1:0]  mem_rdata,
    output logic                mem_ready,
    output logic                mem_ack,
    output logic [31:0]         read_count,
    output logic [31:0]         write_count,
    output logic [`WORD_W-1:0]  last_read_addr,
    output logic [`WORD_W-1:0]  last_write_addr,
    output logic [`LINE_W-1:0]  last_write_line
);

    logic [`WORD_W-1:0] mem_words [65536];

    // start contents depend on every address bit
    function automatic logic [`WORD_W-1:0] initial_word(input logic [`WORD_W-1:0] addr);
        return {addr[7:0], addr[15:8]} ^ 16'hc3a5;
    endfunction

    // answers on falling edges, 1 to 6 cycles after a request is seen
    initial begin
        int unsigned        delay;
        logic               pending;
        logic [`LINE_W-1:0] data;

        void'($urandom(32'hf7d3));
        for (int a = 0; a < 65536; a++) begin
            mem_words[16'(a)] = initial_word(16'(a));
        end
        delay           = 0;
        pending         = 1'b0;
        data            = '0;
        mem_rdata       = '0;
        mem_ready       = 1'b0;
        mem_ack         = 1'b0;
        read_count      = '0;
        write_count     = '0;
        last_read_addr  = '0;
        last_write_addr = '0;
        last_write_line = '0;
        forever begin
            @(negedge clk);
            if (mem_ready || mem_ack) begin
                // responses are one cycle pulses
                mem_ready <= 1'b0;
                mem_ack   <= 1'b0;
            end else if (!reset_n) begin
                pending = 1'b0;
            end else if (mem_read || mem_write) begin
                if (!pending) begin
                    pending = 1'b1;
                    delay   = 1 + ($urandom % 6);
                end
                delay = delay - 1;
                if (delay == 0) begin
                    pending = 1'b0;
                    if (mem_write) begin
                        for (int i = 0; i < `LINE_WORDS; i++) begin
                            mem_words[{mem_addr[`WORD_W-1:`OFFSET_W], 2'(i)}] =
                                mem_wdata[i*`WORD_W +: `WORD_W];
                        end
                        // write-back log
                        write_count     <= write_count + 1;
                        last_write_addr <= mem_addr;
                        last_write_line <= mem_wdata;
                        mem_ack         <= 1'b1;
                    end else begin
                        for (int i = 0; i < `LINE_WORDS; i++) begin
                            data[i*`WORD_W +: `WORD_W] =
                                mem_words[{mem_addr[`WORD_W-1:`OFFSET_W], 2'(i)}];
                        end
                        read_count     <= read_count + 1;
                        last_read_addr <= mem_addr;
                        mem_rdata      <= data;
                        mem_ready      <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_data_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "data_cache_params.svh"

module tb_data_cache;

    // falling edges to wait before giving up
    localparam int RESPONSE_TIMEOUT = 100;
    localparam int RESET_TIMEOUT    = 20;

    logic                clk;
    logic                reset_n;
    logic                cpu_valid;
    logic                cpu_read;
    logic                cpu_write;
    logic [`WORD_W-1:0]  cpu_addr;
    logic [`WORD_W-1:0]  cpu_wdata;
    logic [`WORD_W-1:0]  cpu_rdata;
    logic                cpu_read_ready;
    logic                cpu_write_ack;
    logic                mem_read;
    logic                mem_write;
    logic [`WORD_W-1:0]  mem_addr;
    logic [`LINE_W-1:0]  mem_wdata;
    logic [`LINE_W-1:0]  mem_rdata;
    logic                mem_ready;
    logic                mem_ack;
    logic [31:0]         read_count;
    logic [31:0]         write_count;
    logic [`WORD_W-1:0]  last_read_addr;
    logic [`WORD_W-1:0]  last_write_addr;
    logic [`LINE_W-1:0]  last_write_line;

    // last word written to each address is what a read must return
    logic [`WORD_W-1:0]  shadow [65536];
    int                  error_count;

    // operation table with one entry per row in each queue
    logic                row_write [$];
    logic [`WORD_W-1:0]  row_addr [$];
    logic [`WORD_W-1:0]  row_wdata [$];
    logic                row_miss [$];
    logic                row_wb [$];
    logic [`WORD_W-1:0]  row_wb_addr [$];

    tb_clock_gen clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    tb_memory memory (
        .clk             (clk),
        .reset_n         (reset_n),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .mem_ready       (mem_ready),
        .mem_ack         (mem_ack),
        .read_count      (read_count),
        .write_count     (write_count),
        .last_read_addr  (last_read_addr),
        .last_write_addr (last_write_addr),
        .last_write_line (last_write_line)
    );

    data_cache i_dut (
        .clk            (clk),
        .reset_n        (reset_n),
        .cpu_valid      (cpu_valid),
        .cpu_read       (cpu_read),
        .cpu_write      (cpu_write),
        .cpu_addr       (cpu_addr),
        .cpu_wdata      (cpu_wdata),
        .cpu_rdata      (cpu_rdata),
        .cpu_read_ready (cpu_read_ready),
        .cpu_write_ack  (cpu_write_ack),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .mem_ready      (mem_ready),
        .mem_ack        (mem_ack)
    );

    function automatic logic [`WORD_W-1:0] initial_word(input logic [`WORD_W-1:0] addr);
        return {addr[7:0], addr[15:8]} ^ 16'hc3a5;
    endfunction

    function automatic logic [`WORD_W-1:0] line_address(input logic [`WORD_W-1:0] addr);
        return {addr[`WORD_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
    endfunction

    // expected line with word 0 in the low bits
    function automatic logic [`LINE_W-1:0] shadow_line(input logic [`WORD_W-1:0] addr);
        logic [`LINE_W-1:0] data;
        for (int i = 0; i < `LINE_WORDS; i++) begin
            data[i*`WORD_W +: `WORD_W] = shadow[{addr[`WORD_W-1:`OFFSET_W], 2'(i)}];
        end
        return data;
    endfunction

    task automatic abort_run(input string reason);
        error_count++;
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic add_row(input logic write, input logic [15:0] addr, input logic [15:0] wdata,
                           input logic miss, input logic wb, input logic [15:0] wb_addr);
        row_write.push_back(write);
        row_addr.push_back(addr);
        row_wdata.push_back(wdata);
        row_miss.push_back(miss);
        row_wb.push_back(wb);
        row_wb_addr.push_back(wb_addr);
    endtask

    // write, addr, wdata, miss expected, write-back expected, write-back line
    task automatic build_table();
        // cold miss, write hits and LRU fill of way 1 in set 0
        add_row(1'b0, 16'h0001, 16'h0000, 1'b1, 1'b0, 16'h0000);
        add_row(1'b0, 16'h0006, 16'h0000, 1'b1, 1'b0, 16'h0000);
        add_row(1'b1, 16'h0002, 16'hbeef, 1'b0, 1'b0, 16'h0000);
        add_row(1'b0, 16'h0002, 16'h0000, 1'b0, 1'b0, 16'h0000);
        add_row(1'b1, 16'h0003, 16'h1234, 1'b0, 1'b0, 16'h0000);
        add_row(1'b0, 16'h0009, 16'h0000, 1'b1, 1'b0, 16'h0000);
        // third tag evicts the dirty LRU line, which is then read back
        add_row(1'b0, 16'h0012, 16'h0000, 1'b1, 1'b1, 16'h0000);
        add_row(1'b0, 16'h0002, 16'h0000, 1'b1, 1'b0, 16'h0000);
        add_row(1'b0, 16'h0003, 16'h0000, 1'b0, 1'b0, 16'h0000);
        // write miss followed by the neighbouring word
        add_row(1'b1, 16'h0019, 16'ha55a, 1'b1, 1'b0, 16'h0000);
        add_row(1'b0, 16'h0018, 16'h0000, 1'b0, 1'b0, 16'h0000);
        add_row(1'b0, 16'h0019, 16'h0000, 1'b0, 1'b0, 16'h0000);
        add_row(1'b0, 16'h0008, 16'h0000, 1'b1, 1'b0, 16'h0000);
        add_row(1'b0, 16'h0001, 16'h0000, 1'b1, 1'b1, 16'h0018);
        add_row(1'b0, 16'h0019, 16'h0000, 1'b1, 1'b0, 16'h0000);
        // in set 1 a hit keeps tag 0 while tag 1 is evicted
        add_row(1'b0, 16'h000d, 16'h0000, 1'b1, 1'b0, 16'h0000);
        add_row(1'b0, 16'h0004, 16'h0000, 1'b0, 1'b0, 16'h0000);
        add_row(1'b0, 16'h0015, 16'h0000, 1'b1, 1'b0, 16'h0000);
        add_row(1'b0, 16'h0005, 16'h0000, 1'b0, 1'b0, 16'h0000);
        add_row(1'b0, 16'h000e, 16'h0000, 1'b1, 1'b0, 16'h0000);
        // write misses that push dirty lines out
        add_row(1'b1, 16'h000f, 16'h0f0f, 1'b0, 1'b0, 16'h0000);
        add_row(1'b1, 16'h0024, 16'h2424, 1'b1, 1'b0, 16'h0000);
        add_row(1'b1, 16'h002d, 16'hd2d2, 1'b1, 1'b1, 16'h000c);
        add_row(1'b0, 16'h000f, 16'h0000, 1'b1, 1'b1, 16'h0024);
        add_row(1'b0, 16'h002d, 16'h0000, 1'b0, 1'b0, 16'h0000);
    endtask

    // returns the number of falling edges until the answer pulse
    task automatic wait_for_response(input logic write, output int cycles);
        logic answered;
        answered = 1'b0;
        cycles   = 0;
        while (!answered) begin
            @(negedge clk);
            cycles++;
            answered = write ? cpu_write_ack : cpu_read_ready;
            if (!answered && cycles >= RESPONSE_TIMEOUT) begin
                abort_run("the cache did not answer the CPU request in time");
            end
        end
    endtask

    initial begin
        int                 cycles;
        logic [31:0]        reads_before;
        logic [31:0]        writes_before;
        logic [`WORD_W-1:0] addr;

        cpu_valid   = 1'b0;
        cpu_read    = 1'b0;
        cpu_write   = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        error_count = 0;
        for (int a = 0; a < 65536; a++) begin
            shadow[16'(a)] = initial_word(16'(a));
        end
        build_table();

        cycles = 0;
        while (reset_n !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                abort_run("reset was never released");
            end
        end
        @(negedge clk);
        check_value("cpu_read_ready", 64'(cpu_read_ready), 64'(1'b0));
        check_value("cpu_write_ack", 64'(cpu_write_ack), 64'(1'b0));
        check_value("mem_read", 64'(mem_read), 64'(1'b0));
        check_value("mem_write", 64'(mem_write), 64'(1'b0));

        for (int row = 0; row < row_addr.size(); row++) begin
            addr          = row_addr[row];
            reads_before  = read_count;
            writes_before = write_count;
            cpu_valid     = 1'b1;
            cpu_read      = !row_write[row];
            cpu_write     = row_write[row];
            cpu_addr      = addr;
            cpu_wdata     = row_wdata[row];
            wait_for_response(row_write[row], cycles);

            // a hit answers before the next rising edge
            if (!row_miss[row]) begin
                check_value("hit response cycles", 64'(cycles), 64'(1));
            end
            if (row_write[row]) begin
                shadow[addr] = row_wdata[row];
                check_value("cpu_read_ready", 64'(cpu_read_ready), 64'(1'b0));
            end else begin
                check_value("cpu_rdata", 64'(cpu_rdata), 64'(shadow[addr]));
                check_value("cpu_write_ack", 64'(cpu_write_ack), 64'(1'b0));
            end

            check_value("read_count", 64'(read_count),
                        64'(reads_before + 32'(row_miss[row])));
            if (row_miss[row]) begin
                check_value("last_read_addr", 64'(last_read_addr), 64'(line_address(addr)));
            end
            check_value("write_count", 64'(write_count),
                        64'(writes_before + 32'(row_wb[row])));
            if (row_wb[row]) begin
                check_value("last_write_addr", 64'(last_write_addr), 64'(row_wb_addr[row]));
                check_value("last_write_line", 64'(last_write_line),
                            64'(shadow_line(row_wb_addr[row])));
            end

            cpu_valid = 1'b0;
            cpu_read  = 1'b0;
            cpu_write = 1'b0;
            @(negedge clk);
        end

        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== data_cache.f ====
+incdir+hw
hw/cache_pkg.sv
hw/cache_way.sv
hw/cache_controller.sv
hw/data_cache.sv
test/tb_clock_gen.sv
test/tb_memory.sv
test/tb_data_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the data cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_data_cache -f data_cache.f -o tb_data_cache \
    || { echo "build failed"; exit 1; }
sim_output=$(./obj_dir/tb_data_cache 2>&1)
echo "$sim_output"
echo "$sim_output" | grep -q "TESTBENCH PASSED" \
    && echo "simulation run passed" \
    || { echo "simulation run failed"; exit 1; }
